// File: common/isa_pkg.sv
//####################
// RV32I subset definitions for the small in-order core.
// Opcode and ALU enums, field widths, the NOP encoding and the reset PC.
// Import inside a module body, or use scoped names in port lists.
//####################

`default_nettype none

package isa_pkg;

    localparam int xlen       = 32;
    localparam int opcode_w   = 7;
    localparam int reg_addr_w = 5;

    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [xlen-1:0]       word_t;

    // Major opcodes, bits [6:0] of the instruction word
    typedef enum logic [opcode_w-1:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD    = 2'd0,
        ALU_SUB    = 2'd1,
        ALU_PASS_B = 2'd2
    } alu_op_e;

    // ADDI x0, x0, 0
    localparam word_t instr_nop = 32'h0000_0013;

    localparam word_t reset_pc = 32'h0000_0000;

endpackage

`default_nettype wire

// File: common/pipe_pkg.sv
//####################
// Pipeline structs shared by the core blocks.
// Stage registers, the memory bus request, the retire port
// and the owner tag of a pending bus response.
//####################

`default_nettype none

package pipe_pkg;

    // Request on the shared memory bus, one strobe per access
    typedef struct packed {
        logic          valid;
        isa_pkg::word_t addr;
        logic          we;
        isa_pkg::word_t wdata;
    } bus_req_s;

    // Fetched instruction entering decode-execute
    typedef struct packed {
        logic          valid;
        isa_pkg::word_t pc;
        isa_pkg::word_t instr;
    } if2ex_s;

    // Memory operation, same cycle as decode-execute
    typedef struct packed {
        logic          valid;
        logic          we;
        isa_pkg::word_t addr;
        isa_pkg::word_t wdata;
    } ex2lsu_s;

    // Writeback stage register
    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    pc;
        isa_pkg::reg_addr_t rd;
        isa_pkg::word_t    result;
        logic              is_load;
    } ex2wb_s;

    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    pc;
        isa_pkg::reg_addr_t rd;
        isa_pkg::word_t    value;
    } retire_s;

    // Who gets the read word in the cycle after a grant
    typedef enum logic {
        OWNER_FETCH = 1'b0,
        OWNER_LSU   = 1'b1
    } grant_owner_e;

endpackage

`default_nettype wire

// File: source/reg_file.sv
//####################
// General register file, x1 to x31.
// Two combinational reads, one write at the clock edge.
//####################

`default_nettype none

module reg_file (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire isa_pkg::reg_addr_t rs1_addr_i,
    input  wire isa_pkg::reg_addr_t rs2_addr_i,
    output isa_pkg::word_t          rs1_data_o,
    output isa_pkg::word_t          rs2_data_o,
    input  wire                     wr_en_i,
    input  wire isa_pkg::reg_addr_t wr_addr_i,
    input  wire isa_pkg::word_t     wr_data_i
);
    import isa_pkg::*;

    word_t regs_q [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // x0 is hardwired to zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

`default_nettype wire

// File: fetch/fetch_unit.sv
//####################
// Instruction fetch.
// Issues one read per cycle at the PC and presents the word
// to decode-execute in the cycle after the grant.
//####################

`default_nettype none

module fetch_unit (
    input  wire                 clk,
    input  wire                 rst_n,
    output pipe_pkg::bus_req_s  if_req_o,
    input  wire                 if_gnt_i,
    input  wire isa_pkg::word_t if_rdata_i,
    input  wire                 redirect_valid_i,
    input  wire isa_pkg::word_t redirect_pc_i,
    output pipe_pkg::if2ex_s    if2ex_o
);
    import isa_pkg::*;

    logic  fetch_en_q;
    word_t pc_q;
    logic  pend_valid_q;
    logic  pend_flush_q;
    word_t pend_pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_en_q   <= 1'b0;
            pc_q         <= reset_pc;
            pend_valid_q <= 1'b0;
            pend_flush_q <= 1'b0;
        end else begin
            fetch_en_q   <= 1'b1;
            pend_valid_q <= if_gnt_i;
            // Fetch in flight while a branch is taken is wrong-path
            pend_flush_q <= redirect_valid_i;
            if (redirect_valid_i) begin
                pc_q <= redirect_pc_i;
            end else if (if_gnt_i) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        pend_pc_q <= pc_q;
    end

    // Ungranted requests stay up with the same PC
    assign if_req_o.valid = fetch_en_q;
    assign if_req_o.addr  = pc_q;
    assign if_req_o.we    = 1'b0;
    assign if_req_o.wdata = '0;

    assign if2ex_o.valid = pend_valid_q && !pend_flush_q;
    assign if2ex_o.pc    = pend_pc_q;
    assign if2ex_o.instr = pend_flush_q ? instr_nop : if_rdata_i;

endmodule

`default_nettype wire

// File: source/decode_execute.sv
//####################
// Decode and execute stage.
// Forwards the writeback result, runs the ALU, resolves BEQ,
// starts memory accesses and holds the writeback stage register.
//####################

`default_nettype none

module decode_execute (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire pipe_pkg::if2ex_s   if2ex_i,
    output isa_pkg::reg_addr_t      rs1_addr_o,
    output isa_pkg::reg_addr_t      rs2_addr_o,
    input  wire isa_pkg::word_t     rs1_data_i,
    input  wire isa_pkg::word_t     rs2_data_i,
    input  wire isa_pkg::word_t     wb_result_i,
    output logic                    redirect_valid_o,
    output isa_pkg::word_t          redirect_pc_o,
    output pipe_pkg::ex2lsu_s       ex2lsu_o,
    output pipe_pkg::ex2wb_s        ex2wb_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t     instr;
    opcode_e   opcode;
    reg_addr_t rd_sel;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_b;
    word_t     op_a;
    word_t     op_b;
    word_t     alu_b;
    word_t     alu_out;
    alu_op_e   alu_op;
    logic      is_load;
    logic      is_store;
    logic      is_branch;
    ex2wb_s    ex2wb_q;

    assign instr  = if2ex_i.instr;
    assign opcode = opcode_e'(instr[6:0]);

    assign rs1_addr_o = instr[19:15];
    assign rs2_addr_o = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // Result being written this cycle replaces a stale register read
    assign op_a = (ex2wb_q.valid && ex2wb_q.rd != '0 && ex2wb_q.rd == rs1_addr_o)
                  ? wb_result_i : rs1_data_i;
    assign op_b = (ex2wb_q.valid && ex2wb_q.rd != '0 && ex2wb_q.rd == rs2_addr_o)
                  ? wb_result_i : rs2_data_i;

    assign is_load   = (opcode == LOAD);
    assign is_store  = (opcode == STORE);
    assign is_branch = (opcode == BRANCH);

    always_comb begin
        alu_op = ALU_PASS_B;
        alu_b  = '0;
        rd_sel = '0;
        case (opcode)
            OP: begin
                alu_op = instr[30] ? ALU_SUB : ALU_ADD;
                alu_b  = op_b;
                rd_sel = instr[11:7];
            end
            OP_IMM, LOAD: begin
                alu_op = ALU_ADD;
                alu_b  = imm_i;
                rd_sel = instr[11:7];
            end
            // Store data becomes the retired value
            STORE: alu_b = op_b;
            BRANCH: begin
                alu_op = ALU_SUB;
                alu_b  = op_b;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_out = op_a + alu_b;
            ALU_SUB: alu_out = op_a - alu_b;
            default: alu_out = alu_b;
        endcase
    end

    // BEQ taken when the difference is zero
    assign redirect_valid_o = if2ex_i.valid && is_branch && (alu_out == '0);
    assign redirect_pc_o    = if2ex_i.pc + imm_b;

    assign ex2lsu_o.valid = if2ex_i.valid && (is_load || is_store);
    assign ex2lsu_o.we    = is_store;
    assign ex2lsu_o.addr  = op_a + (is_store ? imm_s : imm_i);
    assign ex2lsu_o.wdata = op_b;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex2wb_q.valid <= 1'b0;
        end else begin
            ex2wb_q.valid <= if2ex_i.valid;
        end
        ex2wb_q.pc      <= if2ex_i.pc;
        ex2wb_q.rd      <= rd_sel;
        ex2wb_q.result  <= is_branch ? '0 : alu_out;
        ex2wb_q.is_load <= is_load;
    end

    assign ex2wb_o = ex2wb_q;

endmodule

`default_nettype wire

// File: lsu/load_store_unit.sv
//####################
// Load-store unit.
// Word accesses only. The bus answers one cycle after the
// request, so the read word goes straight on to writeback.
//####################

`default_nettype none

module load_store_unit (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire pipe_pkg::ex2lsu_s  ex2lsu_i,
    output pipe_pkg::bus_req_s      lsu_req_o,
    input  wire isa_pkg::word_t     lsu_rdata_i,
    output isa_pkg::word_t          load_data_o
);
    import isa_pkg::*;

    logic load_pend_q;

    // Set for the response cycle of a read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_pend_q <= 1'b0;
        end else begin
            load_pend_q <= ex2lsu_i.valid && !ex2lsu_i.we;
        end
    end

    assign lsu_req_o.valid = ex2lsu_i.valid;
    assign lsu_req_o.addr  = {ex2lsu_i.addr[xlen-1:2], 2'b00};
    assign lsu_req_o.we    = ex2lsu_i.we;
    assign lsu_req_o.wdata = ex2lsu_i.wdata;

    // Zero outside a load response
    assign load_data_o = load_pend_q ? lsu_rdata_i : '0;

endmodule

`default_nettype wire

// File: source/bus_arbiter.sv
//####################
// Memory bus arbiter.
// Fixed priority to the LSU; fetch only gets the bus when the
// LSU is idle. The read word is steered to last cycle's owner.
//####################

`default_nettype none

module bus_arbiter (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire pipe_pkg::bus_req_s  if_req_i,
    input  wire pipe_pkg::bus_req_s  lsu_req_i,
    output logic                     if_gnt_o,
    output pipe_pkg::bus_req_s       mem_req_o,
    input  wire isa_pkg::word_t      mem_rdata_i,
    output isa_pkg::word_t           if_rdata_o,
    output isa_pkg::word_t           lsu_rdata_o
);
    import pipe_pkg::*;

    grant_owner_e owner_q;

    assign if_gnt_o  = if_req_i.valid && !lsu_req_i.valid;
    assign mem_req_o = lsu_req_i.valid ? lsu_req_i : if_req_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner_q <= OWNER_FETCH;
        end else begin
            owner_q <= lsu_req_i.valid ? OWNER_LSU : OWNER_FETCH;
        end
    end

    assign if_rdata_o  = (owner_q == OWNER_FETCH) ? mem_rdata_i : '0;
    assign lsu_rdata_o = (owner_q == OWNER_LSU) ? mem_rdata_i : '0;

endmodule

`default_nettype wire

// File: source/core_top.sv
//####################
// Top level of the three-stage core.
// Connects fetch, decode-execute, register file, LSU and the bus
// arbiter; writeback muxing and the retire port live here.
//####################

`default_nettype none

module core_top (
    input  wire                  clk,
    input  wire                  rst_n,
    output pipe_pkg::bus_req_s   mem_req_o,
    input  wire isa_pkg::word_t  mem_rdata_i,
    output pipe_pkg::retire_s    retire_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    bus_req_s  if_req;
    bus_req_s  lsu_req;
    logic      if_gnt;
    word_t     if_rdata;
    word_t     lsu_rdata;
    if2ex_s    if2ex;
    ex2lsu_s   ex2lsu;
    ex2wb_s    ex2wb;
    logic      redirect_valid;
    word_t     redirect_pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     lsu_load_data;
    word_t     wb_result;

    fetch_unit fetch_unit_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .if_req_o         (if_req),
        .if_gnt_i         (if_gnt),
        .if_rdata_i       (if_rdata),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .if2ex_o          (if2ex)
    );

    decode_execute decode_execute_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .if2ex_i          (if2ex),
        .rs1_addr_o       (rs1_addr),
        .rs2_addr_o       (rs2_addr),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .wb_result_i      (wb_result),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc),
        .ex2lsu_o         (ex2lsu),
        .ex2wb_o          (ex2wb)
    );

    reg_file reg_file_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_en_i    (ex2wb.valid),
        .wr_addr_i  (ex2wb.rd),
        .wr_data_i  (wb_result)
    );

    load_store_unit load_store_unit_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex2lsu_i    (ex2lsu),
        .lsu_req_o   (lsu_req),
        .lsu_rdata_i (lsu_rdata),
        .load_data_o (lsu_load_data)
    );

    bus_arbiter bus_arbiter_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .if_req_i    (if_req),
        .lsu_req_i   (lsu_req),
        .if_gnt_o    (if_gnt),
        .mem_req_o   (mem_req_o),
        .mem_rdata_i (mem_rdata_i),
        .if_rdata_o  (if_rdata),
        .lsu_rdata_o (lsu_rdata)
    );

    // Writeback: a load takes the word returned this cycle
    assign wb_result = ex2wb.is_load ? lsu_load_data : ex2wb.result;

    assign retire_o.valid = ex2wb.valid;
    assign retire_o.pc    = ex2wb.pc;
    assign retire_o.rd    = ex2wb.rd;
    assign retire_o.value = wb_result;

endmodule

`default_nettype wire

// File: testbench/core_chk.sv
//####################
// Assertions on the bus arbiter, attached with bind.
// LSU priority as seen by fetch, bus release after an LSU
// access and idle bus in reset.
//####################

`default_nettype none

module core_chk (
    input wire                     clk,
    input wire                     rst_n,
    input wire pipe_pkg::bus_req_s if_req_i,
    input wire pipe_pkg::bus_req_s lsu_req_i,
    input wire                     if_gnt_o,
    input wire pipe_pkg::bus_req_s mem_req_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned error_count = 0;

    // A fetch blocked by the LSU stays up with the same PC
    lsu_blocks_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        (lsu_req_i.valid && if_req_i.valid) |=> (if_req_i.valid && $stable(if_req_i.addr)))
        else begin
            error_count++;
            $error("fetch request not held while the LSU had the bus");
        end

    // One cycle of LSU access, then the bus goes back to fetch
    lsu_releases_bus: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_req_i.valid |=> (!lsu_req_i.valid && if_gnt_o))
        else begin
            error_count++;
            $error("LSU kept the bus past its access cycle");
        end

    // Sync reset, so the bus is idle from the cycle after a reset edge
    idle_in_reset: assert property (@(posedge clk)
        !rst_n |=> !(mem_req_o.valid || lsu_req_i.valid || if_gnt_o))
        else begin
            error_count++;
            $error("bus activity during reset");
        end

endmodule

`default_nettype wire

// File: testbench/core_tb.sv
//####################
// Testbench for the three-stage core.
// Builds a random RV32I program, runs it from a memory model
// and checks each retired instruction against an ISA model.
//####################

`default_nettype none

module core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int prog_len   = 40;
    localparam int data_base  = 64;
    localparam int data_words = 16;
    localparam int k_add      = 0;
    localparam int k_sub      = 1;
    localparam int k_addi     = 2;
    localparam int k_lw       = 3;
    localparam int k_sw       = 4;
    localparam int k_beq      = 5;

    logic     clk = 1'b0;
    logic     rst_n = 1'b0;
    word_t    mem_rdata;
    bus_req_s mem_req;
    retire_s  retire;

    word_t       mem [256];
    word_t       rd_word;
    logic [31:0] seed;
    // Program in decoded form, read by the reference model
    int          kind_a [prog_len];
    int          rd_a [prog_len];
    int          rs1_a [prog_len];
    int          rs2_a [prog_len];
    int          imm_a [prog_len];
    word_t       exp_pc [$];
    int          exp_rd [$];
    word_t       exp_val [$];
    word_t       ref_data [data_words];
    int          exp_count = 0;
    int          ret_idx = 0;

    always #4 clk = ~clk;

    core_top core_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_req_o   (mem_req),
        .mem_rdata_i (mem_rdata),
        .retire_o    (retire)
    );

    bind bus_arbiter core_chk core_chk_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .if_req_i  (if_req_i),
        .lsu_req_i (lsu_req_i),
        .if_gnt_o  (if_gnt_o),
        .mem_req_o (mem_req_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t fill_word(input int idx);
        return 32'hc0de_0000 | (32'(idx) * 32'h0000_0101);
    endfunction

    function automatic word_t encode(input int kind, input int rd, input int rs1,
                                     input int rs2, input int imm);
        logic [4:0]  d;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [11:0] i12;
        logic [12:0] b13;
        d   = 5'(rd);
        s1  = 5'(rs1);
        s2  = 5'(rs2);
        i12 = 12'(imm);
        b13 = 13'(imm);
        case (kind)
            k_add:   return {7'b0000000, s2, s1, 3'b000, d, 7'b0110011};
            k_sub:   return {7'b0100000, s2, s1, 3'b000, d, 7'b0110011};
            k_addi:  return {i12, s1, 3'b000, d, 7'b0010011};
            k_lw:    return {i12, s1, 3'b010, d, 7'b0000011};
            k_sw:    return {i12[11:5], s2, s1, 3'b010, i12[4:0], 7'b0100011};
            default: return {b13[12], b13[10:5], s2, s1, 3'b000, b13[4:1], b13[11], 7'b1100011};
        endcase
    endfunction

    task automatic make_instr(input int i, input logic [31:0] r);
        int kind;
        case (r[31:29])
            3'd0, 3'd7: kind = k_add;
            3'd1:       kind = k_sub;
            3'd2, 3'd3: kind = k_addi;
            3'd4:       kind = k_lw;
            3'd5:       kind = k_sw;
            // Forward branches must still land on or before the self loop
            default:    kind = (i < prog_len - 2) ? k_beq : k_addi;
        endcase
        kind_a[i] = kind;
        rd_a[i]   = int'(r[28:26] % 3'd7) + 1;
        rs1_a[i]  = int'(r[25:23]);
        rs2_a[i]  = int'(r[22:20]);
        imm_a[i]  = int'($signed(r[19:8]));
        if (kind == k_lw || kind == k_sw) begin
            rs1_a[i] = 0;
            imm_a[i] = data_base * 4 + int'(r[17:14]) * 4;
        end else if (kind == k_beq) begin
            imm_a[i] = r[19] ? 12 : 8;
            if (r[18]) begin
                rs2_a[i] = rs1_a[i];
            end
        end
        mem[i] = encode(kind, rd_a[i], rs1_a[i], rs2_a[i], imm_a[i]);
    endtask

    // ISA-level model, fills the expected retire list and data region
    function automatic int run_reference();
        word_t regs [8];
        word_t v;
        int    i;
        int    next;
        int    rd_ret;
        for (int r = 0; r < 8; r++) begin
            regs[r] = '0;
        end
        for (int k = 0; k < data_words; k++) begin
            ref_data[k] = fill_word(data_base + k);
        end
        i = 0;
        while (i < prog_len) begin
            next   = i + 1;
            rd_ret = rd_a[i];
            case (kind_a[i])
                k_add:  v = regs[rs1_a[i]] + regs[rs2_a[i]];
                k_sub:  v = regs[rs1_a[i]] - regs[rs2_a[i]];
                k_addi: v = regs[rs1_a[i]] + 32'(imm_a[i]);
                k_lw:   v = ref_data[(imm_a[i] - data_base * 4) / 4];
                k_sw: begin
                    v = regs[rs2_a[i]];
                    ref_data[(imm_a[i] - data_base * 4) / 4] = v;
                    rd_ret = 0;
                end
                default: begin
                    // BEQ retires rd zero and value zero, taken or not
                    v      = '0;
                    rd_ret = 0;
                    if (regs[rs1_a[i]] == regs[rs2_a[i]]) begin
                        next = i + imm_a[i] / 4;
                    end
                end
            endcase
            if (rd_ret != 0) begin
                regs[rd_ret] = v;
            end
            exp_pc.push_back(reset_pc + 32'(i * 4));
            exp_rd.push_back(rd_ret);
            exp_val.push_back(v);
            i = next;
        end
        // Self loop retires once as the last expected entry
        exp_pc.push_back(reset_pc + 32'(prog_len * 4));
        exp_rd.push_back(0);
        exp_val.push_back('0);
        return exp_pc.size();
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h",
                                        name, got, expected));
        end
    endtask

    initial begin
        mem_rdata = '0;
        rd_word   = '0;
        seed      = 32'd97912;
        for (int a = 0; a < 256; a++) begin
            mem[a] = fill_word(a);
        end
        for (int i = 0; i < prog_len; i++) begin
            seed = lcg_next(seed);
            make_instr(i, seed);
        end
        // BEQ x0, x0, 0 parks the core
        mem[prog_len] = encode(k_beq, 0, 0, 0, 0);
        exp_count = run_reference();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait (ret_idx == exp_count);
        @(posedge clk);
        for (int k = 0; k < data_words; k++) begin
            check_value($sformatf("mem[0x%0h]", (data_base + k) * 4),
                        mem[data_base + k], ref_data[k]);
        end
        if (core_top_inst.bus_arbiter_inst.core_chk_inst.error_count != 0) begin
            stop_with_failure("assertion failures were recorded on the bus arbiter");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

    // Requests are taken mid-cycle, read data follows after the next edge
    always @(negedge clk) begin
        if (rst_n === 1'b1 && mem_req.valid === 1'b1) begin
            if (mem_req.addr[31:10] != '0) begin
                stop_with_failure("memory request outside the modeled address range");
            end else if (mem_req.we) begin
                mem[mem_req.addr[9:2]] = mem_req.wdata;
            end else begin
                rd_word = mem[mem_req.addr[9:2]];
            end
        end
    end

    always @(posedge clk) begin
        #1;
        mem_rdata = rd_word;
    end

    always @(negedge clk) begin
        if (core_top_inst.bus_arbiter_inst.core_chk_inst.error_count != 0) begin
            stop_with_failure("an assertion on the bus arbiter failed");
        end
        if (rst_n !== 1'b1) begin
            check_value("retire_o.valid", 32'(retire.valid), 32'h0);
            check_value("mem_req_o.valid", 32'(mem_req.valid), 32'h0);
        end else if (retire.valid === 1'b1 && ret_idx < exp_count) begin
            check_value("retire_o.pc", retire.pc, exp_pc[ret_idx]);
            check_value("retire_o.rd", 32'(retire.rd), 32'(exp_rd[ret_idx]));
            check_value("retire_o.value", retire.value, exp_val[ret_idx]);
            ret_idx++;
        end
    end

    initial begin
        wait (exp_count > 0 && rst_n === 1'b1);
        repeat (4 * exp_count + 20) @(posedge clk);
        stop_with_failure($sformatf("Timeout: only %0d of %0d instructions retired",
                                    ret_idx, exp_count));
    end

endmodule

`default_nettype wire

// File: vlog.f
common/isa_pkg.sv
common/pipe_pkg.sv
source/reg_file.sv
fetch/fetch_unit.sv
source/decode_execute.sv
lsu/load_store_unit.sv
source/bus_arbiter.sv
source/core_top.sv
testbench/core_chk.sv
testbench/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
